//--- hw/core_pkg.sv
// core shell shared definitions
// bridge regions, command opcodes, status word layout and reset timing
`default_nettype none

package core_pkg;

  // bridge bus width, address and data alike
  localparam int ADDR_W = 32;

  // top address byte per region
  localparam logic [7:0] REGION_LOADER_BYTE = 8'h10;
  localparam logic [7:0] REGION_CMD_BYTE    = 8'hF8;

  typedef enum logic [1:0] {
    region_none,
    region_loader,
    region_cmd
  } bridge_region_t;

  // opcode lives in write data bits 1:0
  typedef enum logic [1:0] {
    op_nop            = 2'd0,
    op_download_start = 2'd1,
    op_download_done  = 2'd2,
    op_soft_reset     = 2'd3
  } cmd_opcode_t;

  // byte offset inside the loader window
  localparam int LOADER_ADDR_W = 20;

  // start button hold, kept short for simulation
  localparam int RESET_HOLD_CYCLES = 255;
  localparam int RESET_TIMER_W     = 16;

  // status word bits, everything else reads zero
  localparam int STATUS_RUNNING_BIT  = 0;
  localparam int STATUS_DOWNLOAD_BIT = 1;
  localparam int STATUS_HOLD_BIT     = 2;

  // face_start in the controller key bitmap
  localparam int START_KEY_BIT = 15;

endpackage

`default_nettype wire

//--- hw/bridge_decode.sv
// bridge decoder
// classifies the top address byte, turns command writes into an opcode
// strobe and muxes read data back to the bridge
`timescale 1ns/100ps
`default_nettype none

module bridge_decode import core_pkg::*; (
  input  wire                clk_74a,
  input  wire                rst,
  input  wire [ADDR_W-1:0]   bridge_addr,
  input  wire                bridge_rd,
  input  wire                bridge_wr,
  input  wire [ADDR_W-1:0]   bridge_wr_data,
  input  wire                core_reset,
  input  wire                download_active,
  input  wire                hold_active,
  output logic [ADDR_W-1:0]  bridge_rd_data,
  output logic               loader_wr,
  output logic               cmd_valid,
  output cmd_opcode_t        cmd_opcode
);

  bridge_region_t    region;
  logic [ADDR_W-1:0] status_word;

  // region from top address byte
  always_comb begin
    case (bridge_addr[ADDR_W-1 -: 8])
      REGION_LOADER_BYTE: region = region_loader;
      REGION_CMD_BYTE:    region = region_cmd;
      default:            region = region_none;
    endcase
  end

  // window writes pass straight on, data_loader registers them
  assign loader_wr = bridge_wr && (region == region_loader);

  ////////////////////////////////////////////////////////////////////////////
  // command strobe

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= bridge_wr && (region == region_cmd);
    end
  end

  // opcode only meaningful with cmd_valid
  always_ff @(posedge clk_74a) begin
    if (bridge_wr && (region == region_cmd)) begin
      cmd_opcode <= cmd_opcode_t'(bridge_wr_data[1:0]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux

  always_comb begin
    status_word = '0;
    // running means core out of reset
    status_word[STATUS_RUNNING_BIT]  = ~core_reset;
    status_word[STATUS_DOWNLOAD_BIT] = download_active;
    status_word[STATUS_HOLD_BIT]     = hold_active;
  end

  // loader window is write only, reads as zero like unmapped space
  always_comb begin
    bridge_rd_data = '0;
    if (bridge_rd && (region == region_cmd)) begin
      bridge_rd_data = status_word;
    end
  end

endmodule

`default_nettype wire

//--- hw/data_loader.sv
// data loader write path
// bridge writes into the loader window become memory writes while a
// download is active, one cycle later, data passed unchanged
`timescale 1ns/100ps
`default_nettype none

module data_loader import core_pkg::*; (
  input  wire                      clk_74a,
  input  wire                      rst,
  input  wire                      loader_wr,
  input  wire                      download_active,
  input  wire [ADDR_W-1:0]         bridge_addr,
  input  wire [ADDR_W-1:0]         bridge_wr_data,
  output logic                     write_en,
  output logic [LOADER_ADDR_W-1:0] write_addr,
  output logic [ADDR_W-1:0]        write_data
);

  logic accept;

  // writes outside a download are dropped
  assign accept = loader_wr && download_active;

  // strobe, one per accepted bridge write, no back-pressure
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      write_en <= 1'b0;
    end else begin
      write_en <= accept;
    end
  end

  // byte offset within the window
  // bridge is little endian so no byte swap
  always_ff @(posedge clk_74a) begin
    if (accept) begin
      write_addr <= bridge_addr[LOADER_ADDR_W-1:0];
      write_data <= bridge_wr_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/reset_control.sv
// core reset control
// download latch, start button synchronizer with edge detect, hold timer,
// and the combined registered core reset
`timescale 1ns/100ps
`default_nettype none

module reset_control import core_pkg::*; (
  input  wire         clk_74a,
  input  wire         rst,
  input  wire         start_key,
  input  wire         cmd_valid,
  input  cmd_opcode_t cmd_opcode,
  output logic        download_active,
  output logic        hold_active,
  output logic        core_reset
);

  logic [2:0]               key_sync;
  logic                     key_prev;
  logic                     key_rise;
  logic                     soft_reset;
  logic                     timer_load;
  logic [RESET_TIMER_W-1:0] reset_timer;
  logic                     download_next;
  logic                     hold_next;

  ////////////////////////////////////////////////////////////////////////////
  // download latch

  always_comb begin
    download_next = download_active;
    if (cmd_valid && (cmd_opcode == op_download_start)) begin
      download_next = 1'b1;
    end else if (cmd_valid && (cmd_opcode == op_download_done)) begin
      download_next = 1'b0;
    end
  end

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      download_active <= 1'b0;
    end else begin
      download_active <= download_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // start button, async to us

  // three flops then edge detect, load lands four edges after the pin
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      key_sync <= '0;
      key_prev <= 1'b0;
    end else begin
      key_sync <= {key_sync[1:0], start_key};
      key_prev <= key_sync[2];
    end
  end

  assign key_rise   = key_sync[2] && !key_prev;
  // soft reset command acts like a press
  assign soft_reset = cmd_valid && (cmd_opcode == op_soft_reset);
  assign timer_load = key_rise || soft_reset;

  // hold timer, a new press restarts it
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      reset_timer <= '0;
    end else if (timer_load) begin
      reset_timer <= RESET_TIMER_W'(RESET_HOLD_CYCLES);
    end else if (reset_timer != '0) begin
      reset_timer <= reset_timer - 1'b1;
    end
  end

  assign hold_active = (reset_timer != '0);

  // hold level after this edge
  assign hold_next = timer_load || (reset_timer > RESET_TIMER_W'(1));

  ////////////////////////////////////////////////////////////////////////////
  // combined reset

  // built from next values so it lines up with download_active and
  // hold_active
  always_ff @(posedge clk_74a) begin
    core_reset <= rst || download_next || hold_next;
  end

endmodule

`default_nettype wire

//--- hw/video_output.sv
// video output stage
// rgb565 to rgb888 by bit replication, blanked outside de, colour and
// syncs registered together
`timescale 1ns/100ps
`default_nettype none

module video_output (
  input  wire         clk_74a,
  input  wire         rst,
  input  wire  [15:0] rgb565,
  input  wire         de,
  input  wire         hs,
  input  wire         vs,
  output logic [23:0] video_rgb,
  output logic        video_de,
  output logic        video_hs,
  output logic        video_vs
);

  logic [23:0] rgb888;

  // top bits fill the new low bits so full scale stays full scale
  assign rgb888 = {rgb565[15:11], rgb565[15:13],
                   rgb565[10:5],  rgb565[10:9],
                   rgb565[4:0],   rgb565[4:2]};

  // one register stage for everything, keeps sync aligned with colour
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
    end else begin
      // blank outside active area
      video_rgb <= de ? rgb888 : 24'h0;
      video_de  <= de;
      video_hs  <= hs;
      video_vs  <= vs;
    end
  end

endmodule

`default_nettype wire

//--- hw/core_top.sv
// core shell top
// bridge decode, data loader, reset control and video output on clk_74a
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; (
  input  wire                      clk_74a,
  input  wire                      rst,
  input  wire [ADDR_W-1:0]         bridge_addr,
  input  wire                      bridge_rd,
  input  wire                      bridge_wr,
  input  wire [ADDR_W-1:0]         bridge_wr_data,
  input  wire [31:0]               cont1_key,
  input  wire [15:0]               rgb565,
  input  wire                      de,
  input  wire                      hs,
  input  wire                      vs,
  output wire [ADDR_W-1:0]         bridge_rd_data,
  output wire                      write_en,
  output wire [LOADER_ADDR_W-1:0]  write_addr,
  output wire [ADDR_W-1:0]         write_data,
  output wire                      core_reset,
  output wire [23:0]               video_rgb,
  output wire                      video_de,
  output wire                      video_hs,
  output wire                      video_vs
);

  wire         loader_wr;
  wire         cmd_valid;
  cmd_opcode_t cmd_opcode;
  wire         download_active;
  wire         hold_active;

  ////////////////////////////////////////////////////////////////////////////
  // bridge side

  bridge_decode bridge_decode_inst (
    .clk_74a         (clk_74a),
    .rst             (rst),
    .bridge_addr     (bridge_addr),
    .bridge_rd       (bridge_rd),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .core_reset      (core_reset),
    .download_active (download_active),
    .hold_active     (hold_active),
    .bridge_rd_data  (bridge_rd_data),
    .loader_wr       (loader_wr),
    .cmd_valid       (cmd_valid),
    .cmd_opcode      (cmd_opcode)
  );

  // only the start key is used from the bitmap
  reset_control reset_control_inst (
    .clk_74a         (clk_74a),
    .rst             (rst),
    .start_key       (cont1_key[START_KEY_BIT]),
    .cmd_valid       (cmd_valid),
    .cmd_opcode      (cmd_opcode),
    .download_active (download_active),
    .hold_active     (hold_active),
    .core_reset      (core_reset)
  );

  data_loader data_loader_inst (
    .clk_74a         (clk_74a),
    .rst             (rst),
    .loader_wr       (loader_wr),
    .download_active (download_active),
    .bridge_addr     (bridge_addr),
    .bridge_wr_data  (bridge_wr_data),
    .write_en        (write_en),
    .write_addr      (write_addr),
    .write_data      (write_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // video

  video_output video_output_inst (
    .clk_74a   (clk_74a),
    .rst       (rst),
    .rgb565    (rgb565),
    .de        (de),
    .hs        (hs),
    .vs        (vs),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

endmodule

`default_nettype wire

//--- verif/core_properties.sv
// core shell assertions
// bound into the top level to watch the command strobe, the hold level and
// the loader write path
`timescale 1ns/100ps
`default_nettype none

module core_properties (
  input wire clk_74a,
  input wire rst,
  input wire cmd_valid,
  input wire loader_wr,
  input wire download_active,
  input wire hold_active,
  input wire core_reset,
  input wire write_en
);

  // command strobe is a single cycle
  cmd_valid_pulse: assert property (
    @(posedge clk_74a) disable iff (rst) cmd_valid |=> !cmd_valid
  ) else $error("cmd_valid held longer than one cycle");

  // running hold timer keeps the core in reset in the same cycle
  hold_in_reset: assert property (
    @(posedge clk_74a) disable iff (rst) hold_active |-> core_reset
  ) else $error("hold_active high while core_reset is low");

  // accepted window write shows up one cycle later
  write_not_lost: assert property (
    @(posedge clk_74a) disable iff (rst) (loader_wr && download_active) |=> write_en
  ) else $error("loader window write during download was lost");

endmodule

`default_nettype wire

//--- verif/core_checker.sv
// core shell checker
// models download state, loader writes and the video stage from the DUT
// inputs, compares reads, writes, video and reset hold length
`timescale 1ns/100ps
`default_nettype none

module core_checker import core_pkg::*; (
  input  wire                      clk_74a,
  input  wire                      rst,
  input  wire [ADDR_W-1:0]         bridge_addr,
  input  wire                      bridge_rd,
  input  wire                      bridge_wr,
  input  wire [ADDR_W-1:0]         bridge_wr_data,
  input  wire [ADDR_W-1:0]         bridge_rd_data,
  input  wire [ADDR_W-1:0]         rd_expect,
  input  wire                      write_en,
  input  wire [LOADER_ADDR_W-1:0]  write_addr,
  input  wire [ADDR_W-1:0]         write_data,
  input  wire                      core_reset,
  input  wire [15:0]               rgb565,
  input  wire                      de,
  input  wire                      hs,
  input  wire                      vs,
  input  wire [23:0]               video_rgb,
  input  wire                      video_de,
  input  wire                      video_hs,
  input  wire                      video_vs,
  input  wire [31:0]               hold_expect,
  output wire [31:0]               error_count
);

  // slack for the key synchronizer
  localparam int HOLD_TOL = 5;

  int                       errors = 0;
  int                       run_len;
  logic                     cmd_seen;
  logic [1:0]               cmd_op;
  logic                     dl_model;
  logic                     exp_we;
  logic [LOADER_ADDR_W-1:0] exp_addr;
  logic [ADDR_W-1:0]        exp_data;
  logic [23:0]              exp_rgb;
  logic                     exp_de;
  logic                     exp_hs;
  logic                     exp_vs;

  assign error_count = errors;

  // each field widened by repeating its top bits
  function automatic logic [23:0] expand565(input logic [15:0] c);
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
    r = c[15:11];
    g = c[10:5];
    b = c[4:0];
    return {r, r[4:2], g, g[5:4], b, b[4:2]};
  endfunction

  task automatic log_mismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare pre-edge DUT outputs, then advance the model

  always @(posedge clk_74a) begin
    if (rst) begin
      run_len  <= 0;
      cmd_seen <= 1'b0;
      dl_model <= 1'b0;
      exp_we   <= 1'b0;
      exp_rgb  <= '0;
      exp_de   <= 1'b0;
      exp_hs   <= 1'b0;
      exp_vs   <= 1'b0;
    end else begin
      if (bridge_rd && (bridge_rd_data !== rd_expect)) begin
        log_mismatch($sformatf("read at %h returned %h, expected %h",
                               bridge_addr, bridge_rd_data, rd_expect));
      end
      if (write_en !== exp_we) begin
        log_mismatch($sformatf("write_en %b, expected %b", write_en, exp_we));
      end
      if (exp_we && ((write_addr !== exp_addr) || (write_data !== exp_data))) begin
        log_mismatch($sformatf("memory write %h <- %h, expected %h <- %h",
                               write_addr, write_data, exp_addr, exp_data));
      end
      // download must hold the core in reset
      if (dl_model && (core_reset !== 1'b1)) begin
        log_mismatch("core_reset low during an active download");
      end
      if (video_rgb !== exp_rgb) begin
        log_mismatch($sformatf("video_rgb %h, expected %h", video_rgb, exp_rgb));
      end
      if ({video_de, video_hs, video_vs} !== {exp_de, exp_hs, exp_vs}) begin
        log_mismatch($sformatf("de/hs/vs %b%b%b, expected %b%b%b",
                               video_de, video_hs, video_vs, exp_de, exp_hs, exp_vs));
      end

      // reset hold length, checked on the falling edge when armed
      if (core_reset) begin
        run_len <= run_len + 1;
      end else begin
        if ((run_len != 0) && (hold_expect != 0) &&
            ((run_len < int'(hold_expect) - HOLD_TOL) ||
             (run_len > int'(hold_expect) + HOLD_TOL))) begin
          log_mismatch($sformatf("core_reset held %0d cycles, expected %0d",
                                 run_len, hold_expect));
        end
        run_len <= 0;
      end

      // command write lands as a strobe, then as download state
      cmd_seen <= bridge_wr && (bridge_addr[ADDR_W-1 -: 8] == REGION_CMD_BYTE);
      cmd_op   <= bridge_wr_data[1:0];
      if (cmd_seen && (cmd_op == op_download_start)) begin
        dl_model <= 1'b1;
      end else if (cmd_seen && (cmd_op == op_download_done)) begin
        dl_model <= 1'b0;
      end

      exp_we   <= bridge_wr && (bridge_addr[ADDR_W-1 -: 8] == REGION_LOADER_BYTE) && dl_model;
      exp_addr <= bridge_addr[LOADER_ADDR_W-1:0];
      exp_data <= bridge_wr_data;

      exp_rgb <= de ? expand565(rgb565) : 24'h0;
      exp_de  <= de;
      exp_hs  <= hs;
      exp_vs  <= vs;
    end
  end

endmodule

`default_nettype wire

//--- verif/core_tb.sv
// core shell testbench
// reads bridge, key and video records from the stimulus file and drives
// the top level, the checker module does the comparing
`timescale 1ns/100ps
`default_nettype none

module core_tb import core_pkg::*; ();

  logic                     clk_74a = 1'b0;
  logic                     rst;
  logic [ADDR_W-1:0]        bridge_addr;
  logic                     bridge_rd;
  logic                     bridge_wr;
  logic [ADDR_W-1:0]        bridge_wr_data;
  logic [31:0]              cont1_key;
  logic [15:0]              rgb565;
  logic                     de;
  logic                     hs;
  logic                     vs;
  logic [ADDR_W-1:0]        rd_expect;
  int                       hold_expect;
  wire  [ADDR_W-1:0]        bridge_rd_data;
  wire                      write_en;
  wire  [LOADER_ADDR_W-1:0] write_addr;
  wire  [ADDR_W-1:0]        write_data;
  wire                      core_reset;
  wire  [23:0]              video_rgb;
  wire                      video_de;
  wire                      video_hs;
  wire                      video_vs;
  wire  [31:0]              error_count;

  int                       timeouts = 0;
  int                       bad_records = 0;
  int                       records = 0;
  logic [31:0]              rand_state = 32'h6a2;
  int                       fd;
  string                    line;

  // 40 ns period
  always #20 clk_74a = ~clk_74a;

  core_top core_top_inst (
    .clk_74a        (clk_74a),
    .rst            (rst),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .cont1_key      (cont1_key),
    .rgb565         (rgb565),
    .de             (de),
    .hs             (hs),
    .vs             (vs),
    .bridge_rd_data (bridge_rd_data),
    .write_en       (write_en),
    .write_addr     (write_addr),
    .write_data     (write_data),
    .core_reset     (core_reset),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

  core_checker core_checker_inst (
    .clk_74a        (clk_74a),
    .rst            (rst),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .rd_expect      (rd_expect),
    .write_en       (write_en),
    .write_addr     (write_addr),
    .write_data     (write_data),
    .core_reset     (core_reset),
    .rgb565         (rgb565),
    .de             (de),
    .hs             (hs),
    .vs             (vs),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .hold_expect    (hold_expect),
    .error_count    (error_count)
  );

  // assertions see the internal strobes of the top level
  bind core_top core_properties core_properties_inst (
    .clk_74a         (clk_74a),
    .rst             (rst),
    .cmd_valid       (cmd_valid),
    .loader_wr       (loader_wr),
    .download_active (download_active),
    .hold_active     (hold_active),
    .core_reset      (core_reset),
    .write_en        (write_en)
  );

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic bridge_idle();
    bridge_wr <= 1'b0;
    bridge_rd <= 1'b0;
  endtask

  task automatic drive_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    bridge_rd      <= 1'b0;
  endtask

  task automatic drive_read(input logic [31:0] addr, input logic [31:0] expect_data);
    @(posedge clk_74a);
    bridge_addr <= addr;
    rd_expect   <= expect_data;
    bridge_rd   <= 1'b1;
    bridge_wr   <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_74a);
      bridge_idle();
    end
  endtask

  // every wait is bounded
  task automatic wait_core_reset(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while ((core_reset !== level) && (n < limit)) begin
      @(posedge clk_74a);
      n++;
    end
    if (core_reset !== level) begin
      $display("timeout after %0d cycles waiting for %s", limit, what);
      timeouts++;
    end
  endtask

  task automatic press_start(input int hold_cycles, input int expect_cycles);
    @(posedge clk_74a);
    bridge_idle();
    hold_expect              <= expect_cycles;
    cont1_key[START_KEY_BIT] <= 1'b1;
    repeat (hold_cycles) @(posedge clk_74a);
    cont1_key[START_KEY_BIT] <= 1'b0;
    wait_core_reset(1'b1, 20, "core reset to rise after a start press");
    wait_core_reset(1'b0, 400, "core reset to fall after a start press");
    hold_expect <= 0;
  endtask

  // soft reset hold, already started by a command record
  task automatic watch_hold(input int expect_cycles);
    @(posedge clk_74a);
    bridge_idle();
    hold_expect <= expect_cycles;
    wait_core_reset(1'b1, 20, "core reset to rise after a soft reset");
    wait_core_reset(1'b0, 400, "core reset to fall after a soft reset");
    hold_expect <= 0;
  endtask

  task automatic video_beats(input int n);
    repeat (n) begin
      @(posedge clk_74a);
      bridge_idle();
      rand_state = next_random(rand_state);
      rgb565 <= rand_state[15:0];
      de     <= rand_state[16];
      hs     <= rand_state[17];
      vs     <= rand_state[18];
    end
    @(posedge clk_74a);
    rgb565 <= '0;
    de     <= 1'b0;
    hs     <= 1'b0;
    vs     <= 1'b0;
  endtask

  task automatic reject_record(input string text);
    $display("stimulus record not understood: %s", text);
    bad_records++;
  endtask

  // one line: kind letter then its fields
  task automatic run_record(input string text);
    byte         kind;
    string       rest;
    logic [31:0] f1;
    logic [31:0] f2;
    int          n1;
    int          n2;
    int          got;
    kind = text.getc(0);
    rest = text.substr(1, text.len() - 1);
    records++;
    case (kind)
      "W": begin
        got = $sscanf(rest, "%h %h", f1, f2);
        if (got == 2) drive_write(f1, f2);
        else reject_record(text);
      end
      "R": begin
        got = $sscanf(rest, "%h %h", f1, f2);
        if (got == 2) drive_read(f1, f2);
        else reject_record(text);
      end
      "I": begin
        got = $sscanf(rest, "%d", n1);
        if (got == 1) idle_cycles(n1);
        else reject_record(text);
      end
      "K": begin
        got = $sscanf(rest, "%d %d", n1, n2);
        if (got == 2) press_start(n1, n2);
        else reject_record(text);
      end
      "H": begin
        got = $sscanf(rest, "%d", n1);
        if (got == 1) watch_hold(n1);
        else reject_record(text);
      end
      "V": begin
        got = $sscanf(rest, "%d", n1);
        if (got == 1) video_beats(n1);
        else reject_record(text);
      end
      default: reject_record(text);
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    rst            <= 1'b1;
    bridge_addr    <= '0;
    bridge_rd      <= 1'b0;
    bridge_wr      <= 1'b0;
    bridge_wr_data <= '0;
    cont1_key      <= '0;
    rgb565         <= '0;
    de             <= 1'b0;
    hs             <= 1'b0;
    vs             <= 1'b0;
    rd_expect      <= '0;
    hold_expect    <= 0;
    repeat (2) @(posedge clk_74a);
    rst <= 1'b0;
    wait_core_reset(1'b0, 10, "core reset to release after rst");

    fd = $fopen("verif/core_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file verif/core_stimulus.txt");
      bad_records++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if ((line.len() > 1) && (line.getc(0) != "#")) begin
          run_record(line);
        end
      end
      $fclose(fd);
    end
    idle_cycles(4);

    $display("checker errors %0d, timeouts %0d, bad records %0d, records run %0d",
             error_count, timeouts, bad_records, records);
    if ((error_count == 0) && (timeouts == 0) && (bad_records == 0) && (records > 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/core_stimulus.txt
# W addr data | R addr expected_read | I idle_cycles | V video_beats
# K key_hold_cycles expected_reset_cycles | H expected_reset_cycles
R f8000000 00000001
R 10000000 00000000
R 00400000 00000000
W 10000010 deadbeef
I 2
W f8000000 00000001
I 1
R f8000000 00000002
W 10000000 11223344
W 1012345c a5a55a5a
W 10fffffc 0badf00d
I 1
R 10000000 00000000
W f8000000 00000002
I 1
R f8000000 00000001
W 10000020 cafef00d
I 2
K 10 255
R f8000000 00000001
W f8000000 00000003
I 1
R f8000000 00000004
H 255
R f8000000 00000001
V 200

//--- project.f
hw/core_pkg.sv
hw/bridge_decode.sv
hw/data_loader.sv
hw/reset_control.sv
hw/video_output.sv
hw/core_top.sv
verif/core_properties.sv
verif/core_checker.sv
verif/core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the core shell testbench with Verilator, run it, and decide the
# result from the simulation log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module core_tb -f project.f > build.log 2>&1 &&
./obj_dir/Vcore_tb > sim.log 2>&1

grep -qx "Test completed successfully" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }
